// ==== verilog/sd_host_macros.svh ====
`ifndef SD_HOST_MACROS_SVH
`define SD_HOST_MACROS_SVH

// block layout
`define SD_BLOCK_BYTES      512
`define SD_CRC_BYTES        2

// init and polling limits
`define SD_INIT_IDLE_BYTES  10
`define SD_R1_POLL_BYTES    8
`define SD_ACMD41_TRIES     255
`define SD_TOKEN_POLL_MAX   1024

`define SD_IDLE_BYTE        8'hFF
`define SD_START_TOKEN      8'hFE

`endif

// ==== verilog/sd_spi_pkg.sv ====
package sd_spi_pkg;

   typedef logic [7:0] byte_t;

   // what the link layer does for one request
   typedef enum logic [1:0]
   {
      OP_IDLE_CLOCKS = 2'd0,
      OP_CMD         = 2'd1,
      OP_XFER        = 2'd2
   } link_op_e;

endpackage

// ==== verilog/sd_proto_pkg.sv ====
package sd_proto_pkg;

   typedef enum logic [5:0]
   {
      CMD0   = 6'd0,
      CMD8   = 6'd8,
      CMD17  = 6'd17,
      ACMD41 = 6'd41,
      CMD55  = 6'd55
   } cmd_index_e;

   typedef struct packed
   {
      cmd_index_e  index;
      logic [31:0] arg;
   } sd_cmd_t;

   typedef logic [7:0] r1_t;

   // r1 values the sequencer expects
   localparam r1_t R1_READY = 8'h00;
   localparam r1_t R1_IDLE  = 8'h01;

   typedef enum logic [3:0]
   {
      S_POWERUP, S_IDLE_CLK, S_CMD0, S_CMD8, S_CMD55, S_ACMD41,
      S_READY, S_CMD17, S_TOKEN, S_DATA, S_CRC, S_ERROR
   } host_state_e;

endpackage

// ==== verilog/spi_byte_if.sv ====
`timescale 1ns/1ns

interface spi_byte_if;
   import sd_spi_pkg::*;

   logic  start;
   byte_t tx_byte;
   logic  cs_n;
   logic  busy;
   logic  done;
   byte_t rx_byte;

   modport link   (output start, tx_byte, cs_n, input busy, done, rx_byte);
   modport engine (input start, tx_byte, cs_n, output busy, done, rx_byte);

endinterface

// ==== verilog/sd_link_if.sv ====
`timescale 1ns/1ns

interface sd_link_if;
   import sd_spi_pkg::*;
   import sd_proto_pkg::*;

   logic     start;
   link_op_e op;
   sd_cmd_t  cmd;
   logic     busy;
   logic     done;
   byte_t    rx;

   modport ctrl (output start, op, cmd, input busy, done, rx);
   modport link (input start, op, cmd, output busy, done, rx);
endinterface

// ==== verilog/spi_byte_xfer.sv ====
`timescale 1ns/1ns

module spi_byte_xfer #(
   parameter int SCLK_DIV = 2
) (
   input  logic       clk,
   input  logic       reset,
   spi_byte_if.engine bus,
   input  logic       miso_i,
   output logic       mosi_o,
   output logic       sclk_o,
   output logic       cs_n_o
);
   import sd_spi_pkg::*;

   localparam int DIV_W = $clog2(SCLK_DIV + 1);

   logic [DIV_W-1:0] div_cnt;
   logic [2:0]       bit_cnt;
   logic             busy_q;
   logic             done_q;
   logic             sclk_q;
   logic             tick;
   byte_t            tx_sr;
   byte_t            rx_sr;

   // one sclk half period ends
   assign tick = busy_q && (div_cnt == DIV_W'(SCLK_DIV - 1));

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         busy_q  <= 1'b0;
         done_q  <= 1'b0;
         sclk_q  <= 1'b0;
         div_cnt <= '0;
         bit_cnt <= '0;
      end
      else
      begin
         done_q <= 1'b0;
         if (!busy_q)
         begin
            if (bus.start)
            begin
               busy_q  <= 1'b1;
               div_cnt <= '0;
               bit_cnt <= '0;
            end
         end
         else if (tick)
         begin
            div_cnt <= '0;
            sclk_q  <= ~sclk_q;
            // falling edge of the last bit ends the byte
            if (sclk_q && bit_cnt == 3'd7)
            begin
               busy_q <= 1'b0;
               done_q <= 1'b1;
            end
            else if (sclk_q)
            begin
               bit_cnt <= bit_cnt + 3'd1;
            end
         end
         else
         begin
            div_cnt <= div_cnt + 1'b1;
         end
      end
   end

   // mode 0 samples on rise and shifts on fall
   always_ff @(posedge clk)
   begin
      if (!busy_q && bus.start)
      begin
         tx_sr <= bus.tx_byte;
      end
      else if (tick && !sclk_q)
      begin
         rx_sr <= {rx_sr[6:0], miso_i};
      end
      else if (tick)
      begin
         tx_sr <= {tx_sr[6:0], 1'b1};
      end
   end

   assign mosi_o      = busy_q ? tx_sr[7] : 1'b1;
   assign sclk_o      = sclk_q;
   assign cs_n_o      = bus.cs_n;
   assign bus.busy    = busy_q;
   assign bus.done    = done_q;
   assign bus.rx_byte = rx_sr;

   start_while_busy_a: assert property (@(posedge clk) disable iff (reset)
      bus.start |-> !busy_q);

endmodule

// ==== verilog/sd_link.sv ====
`timescale 1ns/1ns
`include "sd_host_macros.svh"

module sd_link (
   input logic      clk,
   input logic      reset,
   sd_link_if.link  req,
   spi_byte_if.link spi
);
   import sd_spi_pkg::*;

   typedef enum logic [1:0] {L_IDLE, L_ISSUE, L_WAIT} link_state_e;

   localparam int POLL_W = $clog2(`SD_R1_POLL_BYTES);

   link_state_e       state_q;
   link_op_e          op_q;
   logic [2:0]        byte_idx;
   logic [39:0]       frame;
   logic [6:0]        crc_q;
   logic [POLL_W-1:0] poll_cnt;
   logic              cs_q;
   logic              done_q;
   logic              cmd_phase;
   logic              sent;
   byte_t             rx_q;
   byte_t             tx_sel;

   // crc7 with polynomial x^7 + x^3 + 1
   function automatic logic [6:0] crc7_byte(input logic [6:0] crc_in, input byte_t data);
      logic [6:0] c;
      logic       fb;
      c = crc_in;
      for (int i = 7; i >= 0; i--)
      begin
         fb = c[6] ^ data[i];
         c  = {c[5:0], 1'b0};
         if (fb)
         begin
            c = c ^ 7'h09;
         end
      end
      return c;
   endfunction

   assign cmd_phase = (op_q == OP_CMD) && (byte_idx < 3'd6);
   assign sent      = (state_q == L_WAIT) && spi.done;
   assign tx_sel    = !cmd_phase ? byte_t'(`SD_IDLE_BYTE) :
                      (byte_idx == 3'd5) ? {crc_q, 1'b1} : frame[39:32];

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         state_q  <= L_IDLE;
         op_q     <= OP_XFER;
         cs_q     <= 1'b1;
         done_q   <= 1'b0;
         byte_idx <= '0;
         poll_cnt <= '0;
      end
      else
      begin
         done_q <= 1'b0;
         case (state_q)
            L_IDLE:
               if (req.start)
               begin
                  op_q     <= req.op;
                  cs_q     <= (req.op == OP_IDLE_CLOCKS);
                  byte_idx <= '0;
                  poll_cnt <= '0;
                  state_q  <= L_ISSUE;
               end
            L_ISSUE:
               state_q <= L_WAIT;
            default:
               if (spi.done)
               begin
                  state_q <= L_ISSUE;
                  if (op_q != OP_CMD)
                  begin
                     done_q  <= 1'b1;
                     state_q <= L_IDLE;
                  end
                  else if (cmd_phase)
                  begin
                     byte_idx <= byte_idx + 3'd1;
                  end
                  // r1 has a clear top bit
                  else if (!spi.rx_byte[7] || poll_cnt == POLL_W'(`SD_R1_POLL_BYTES - 1))
                  begin
                     done_q  <= 1'b1;
                     state_q <= L_IDLE;
                  end
                  else
                  begin
                     poll_cnt <= poll_cnt + 1'b1;
                  end
               end
         endcase
      end
   end

   always_ff @(posedge clk)
   begin
      if (state_q == L_IDLE && req.start)
      begin
         frame <= {2'b01, req.cmd.index, req.cmd.arg};
         crc_q <= '0;
      end
      else if (sent && cmd_phase && byte_idx < 3'd5)
      begin
         crc_q <= crc7_byte(crc_q, frame[39:32]);
         frame <= {frame[31:0], 8'h00};
      end
      if (sent)
      begin
         rx_q <= (op_q == OP_CMD && spi.rx_byte[7]) ? byte_t'(`SD_IDLE_BYTE) : spi.rx_byte;
      end
   end

   assign spi.start   = (state_q == L_ISSUE);
   assign spi.tx_byte = tx_sel;
   assign spi.cs_n    = cs_q;
   assign req.busy    = (state_q != L_IDLE);
   assign req.done    = done_q;
   assign req.rx      = rx_q;

   req_while_busy_a: assert property (@(posedge clk) disable iff (reset)
      req.start |-> state_q == L_IDLE);

endmodule

// ==== verilog/block_fifo.sv ====
`timescale 1ns/1ns

module block_fifo #(
   parameter int DEPTH = 16
) (
   input  logic               clk,
   input  logic               reset,
   input  logic               push_i,
   input  sd_spi_pkg::byte_t  push_data_i,
   output logic               full_o,
   input  logic               pop_i,
   output sd_spi_pkg::byte_t  data_o,
   output logic               valid_o
);
   import sd_spi_pkg::*;

   localparam int AW = $clog2(DEPTH);

   byte_t         mem [DEPTH];
   logic [AW-1:0] rd_ptr;
   logic [AW-1:0] wr_ptr;
   logic [AW:0]   count;
   logic          do_push;
   logic          do_pop;

   function automatic logic [AW-1:0] next_ptr(input logic [AW-1:0] p);
      return (p == AW'(DEPTH - 1)) ? '0 : p + 1'b1;
   endfunction

   assign do_push = push_i && !full_o;
   assign do_pop  = pop_i && valid_o;

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         rd_ptr <= '0;
         wr_ptr <= '0;
         count  <= '0;
      end
      else
      begin
         if (do_push)
         begin
            wr_ptr <= next_ptr(wr_ptr);
         end
         if (do_pop)
         begin
            rd_ptr <= next_ptr(rd_ptr);
         end
         count <= count + (AW+1)'(do_push) - (AW+1)'(do_pop);
      end
   end

   always_ff @(posedge clk)
   begin
      if (do_push)
      begin
         mem[wr_ptr] <= push_data_i;
      end
   end

   assign data_o  = mem[rd_ptr];
   assign valid_o = (count != '0);
   assign full_o  = (count == (AW+1)'(DEPTH));

   push_full_a: assert property (@(posedge clk) disable iff (reset) push_i |-> !full_o);
   pop_empty_a: assert property (@(posedge clk) disable iff (reset) pop_i |-> valid_o);

endmodule

// ==== verilog/sd_host_ctrl.sv ====
`timescale 1ns/1ns
`include "sd_host_macros.svh"

module sd_host_ctrl #(
   parameter int POWERUP_CYCLES = 64
) (
   input  logic              clk,
   input  logic              reset,
   input  logic              rd_block_i,
   input  logic [31:0]       block_addr_i,
   output logic              busy_o,
   output logic              err_o,
   sd_link_if.ctrl           link,
   output logic              push_o,
   output sd_spi_pkg::byte_t push_data_o,
   input  logic              fifo_full_i
);
   import sd_spi_pkg::*;
   import sd_proto_pkg::*;

   host_state_e state_q;
   logic [31:0] cnt;
   logic [31:0] addr_q;
   logic        wait_q;
   logic        start_q;
   logic        need_link;
   logic        issue;
   logic        rsp_done;
   link_op_e    op_q;
   link_op_e    next_op;
   sd_cmd_t     cmd_q;
   sd_cmd_t     next_cmd;
   r1_t         r1;

   // operation wanted by the current state
   always_comb
   begin
      need_link = 1'b1;
      next_op   = OP_CMD;
      next_cmd  = '{index: CMD0, arg: 32'h0};
      case (state_q)
         S_IDLE_CLK:      next_op = OP_IDLE_CLOCKS;
         S_CMD0:          next_cmd = '{index: CMD0, arg: 32'h0};
         S_CMD8:          next_cmd = '{index: CMD8, arg: 32'h0000_01AA};
         S_CMD55:         next_cmd = '{index: CMD55, arg: 32'h0};
         S_ACMD41:        next_cmd = '{index: ACMD41, arg: 32'h4000_0000};
         S_CMD17:         next_cmd = '{index: CMD17, arg: addr_q};
         S_TOKEN, S_CRC:  next_op = OP_XFER;
         S_DATA:
         begin
            // stall the spi clock while the fifo is full
            next_op   = OP_XFER;
            need_link = !fifo_full_i;
         end
         default:         need_link = 1'b0;
      endcase
   end

   assign issue    = need_link && !wait_q && !link.busy;
   assign rsp_done = wait_q && link.done;
   assign r1       = link.rx;

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         state_q <= S_POWERUP;
         cnt     <= '0;
         wait_q  <= 1'b0;
         start_q <= 1'b0;
      end
      else
      begin
         start_q <= issue;
         if (issue)
         begin
            wait_q <= 1'b1;
         end
         else if (rsp_done)
         begin
            wait_q <= 1'b0;
         end
         case (state_q)
            S_POWERUP:
            begin
               cnt <= cnt + 32'd1;
               if (cnt == 32'(POWERUP_CYCLES - 1))
               begin
                  cnt     <= '0;
                  state_q <= S_IDLE_CLK;
               end
            end
            S_IDLE_CLK:
               if (rsp_done)
               begin
                  cnt <= cnt + 32'd1;
                  if (cnt == 32'(`SD_INIT_IDLE_BYTES - 1))
                  begin
                     cnt     <= '0;
                     state_q <= S_CMD0;
                  end
               end
            S_CMD0:
               if (rsp_done)
               begin
                  state_q <= (r1 == R1_IDLE) ? S_CMD8 : S_ERROR;
               end
            S_CMD8:
               if (rsp_done)
               begin
                  state_q <= (r1 == R1_IDLE) ? S_CMD55 : S_ERROR;
               end
            S_CMD55:
               if (rsp_done)
               begin
                  state_q <= (r1 == R1_IDLE) ? S_ACMD41 : S_ERROR;
               end
            S_ACMD41:
               if (rsp_done)
               begin
                  cnt     <= cnt + 32'd1;
                  state_q <= S_CMD55;
                  if (r1 == R1_READY)
                  begin
                     state_q <= S_READY;
                  end
                  else if (cnt == 32'(`SD_ACMD41_TRIES - 1))
                  begin
                     state_q <= S_ERROR;
                  end
               end
            S_READY:
            begin
               cnt <= '0;
               if (rd_block_i)
               begin
                  state_q <= S_CMD17;
               end
            end
            S_CMD17:
               if (rsp_done)
               begin
                  state_q <= (r1 == R1_READY) ? S_TOKEN : S_ERROR;
               end
            S_TOKEN:
               if (rsp_done)
               begin
                  cnt <= cnt + 32'd1;
                  if (link.rx == `SD_START_TOKEN)
                  begin
                     cnt     <= '0;
                     state_q <= S_DATA;
                  end
                  else if (cnt == 32'(`SD_TOKEN_POLL_MAX - 1))
                  begin
                     state_q <= S_ERROR;
                  end
               end
            S_DATA:
               if (rsp_done)
               begin
                  cnt <= cnt + 32'd1;
                  if (cnt == 32'(`SD_BLOCK_BYTES - 1))
                  begin
                     cnt     <= '0;
                     state_q <= S_CRC;
                  end
               end
            S_CRC:
               // crc bytes are clocked in and dropped
               if (rsp_done)
               begin
                  cnt <= cnt + 32'd1;
                  if (cnt == 32'(`SD_CRC_BYTES - 1))
                  begin
                     state_q <= S_READY;
                  end
               end
            default:
               state_q <= S_ERROR;
         endcase
      end
   end

   always_ff @(posedge clk)
   begin
      if (issue)
      begin
         op_q  <= next_op;
         cmd_q <= next_cmd;
      end
      if (state_q == S_READY && rd_block_i)
      begin
         addr_q <= block_addr_i;
      end
   end

   assign link.start  = start_q;
   assign link.op     = op_q;
   assign link.cmd    = cmd_q;
   assign push_o      = (state_q == S_DATA) && rsp_done;
   assign push_data_o = link.rx;
   assign busy_o      = (state_q != S_READY);
   assign err_o       = (state_q == S_ERROR);

endmodule

// ==== verilog/sd_spi_host.sv ====
`timescale 1ns/1ns

module sd_spi_host #(
   parameter int SCLK_DIV       = 2,
   parameter int POWERUP_CYCLES = 64
) (
   input  logic              clk,
   input  logic              reset,
   input  logic              rd_block_i,
   input  logic [31:0]       block_addr_i,
   output logic              busy_o,
   output logic              err_o,
   output sd_spi_pkg::byte_t data_o,
   output logic              data_valid_o,
   input  logic              data_pop_i,
   input  logic              miso_i,
   output logic              mosi_o,
   output logic              sclk_o,
   output logic              cs_n_o
);
   import sd_spi_pkg::*;

   logic  push;
   logic  fifo_full;
   byte_t push_data;

   spi_byte_if spi_bus ();
   sd_link_if  link_bus ();

   sd_host_ctrl #(
      .POWERUP_CYCLES (POWERUP_CYCLES)
   ) ctrl0 (
      .clk          (clk),
      .reset        (reset),
      .rd_block_i   (rd_block_i),
      .block_addr_i (block_addr_i),
      .busy_o       (busy_o),
      .err_o        (err_o),
      .link         (link_bus.ctrl),
      .push_o       (push),
      .push_data_o  (push_data),
      .fifo_full_i  (fifo_full)
   );

   sd_link link0 (
      .clk   (clk),
      .reset (reset),
      .req   (link_bus.link),
      .spi   (spi_bus.link)
   );

   spi_byte_xfer #(
      .SCLK_DIV (SCLK_DIV)
   ) xfer0 (
      .clk    (clk),
      .reset  (reset),
      .bus    (spi_bus.engine),
      .miso_i (miso_i),
      .mosi_o (mosi_o),
      .sclk_o (sclk_o),
      .cs_n_o (cs_n_o)
   );

   block_fifo fifo0 (
      .clk         (clk),
      .reset       (reset),
      .push_i      (push),
      .push_data_i (push_data),
      .full_o      (fifo_full),
      .pop_i       (data_pop_i),
      .data_o      (data_o),
      .valid_o     (data_valid_o)
   );

endmodule

// ==== dv/tb_sd_spi_host.sv ====
`timescale 1ns/1ns
`include "sd_host_macros.svh"

package block_pattern_pkg;

   localparam logic [31:0] PATTERN_SEED = 32'h96f2;

   // one xorshift32 step
   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      logic [31:0] s;
      s = x ^ (x << 13);
      s = s ^ (s >> 17);
      s = s ^ (s << 5);
      return s;
   endfunction

endpackage

module tb_sd_spi_host;
   import sd_spi_pkg::*;
   import block_pattern_pkg::*;

   localparam int TIMEOUT_CYCLES = 50000;
   localparam int HOLD_CYCLES    = 200;
   localparam int FIFO_DEPTH     = 16;

   logic        clk;
   logic        reset;
   logic        rd_block;
   logic [31:0] block_addr;
   logic        busy;
   logic        err;
   byte_t       data;
   logic        data_valid;
   logic        data_pop;
   logic        miso;
   logic        mosi;
   logic        sclk;
   logic        cs_n;
   int          acmd41_busy;
   logic [31:0] addr_limit;
   logic        cmd8_reject;
   logic        crc_err;
   int          data_sent;

   sd_spi_host dut0 (
      .clk          (clk),
      .reset        (reset),
      .rd_block_i   (rd_block),
      .block_addr_i (block_addr),
      .busy_o       (busy),
      .err_o        (err),
      .data_o       (data),
      .data_valid_o (data_valid),
      .data_pop_i   (data_pop),
      .miso_i       (miso),
      .mosi_o       (mosi),
      .sclk_o       (sclk),
      .cs_n_o       (cs_n)
   );

   sd_card_model card0 (
      .reset         (reset),
      .sclk_i        (sclk),
      .mosi_i        (mosi),
      .cs_n_i        (cs_n),
      .miso_o        (miso),
      .acmd41_busy_i (acmd41_busy),
      .addr_limit_i  (addr_limit),
      .cmd8_reject_i (cmd8_reject),
      .crc_err_o     (crc_err),
      .data_sent_o   (data_sent)
   );

   initial
   begin
      clk = 1'b0;
      forever
      begin
         #50 clk = ~clk;
      end
   end

   task automatic stop_run();
      $display("Simulation FAILED");
      $fatal(1, "stopped at the first error");
   endtask

   task automatic check_byte(input byte_t actual, input byte_t expected, input string what);
      if (actual !== expected)
      begin
         $display("error at %0t ns: %s is %02h, expected %02h", $time, what, actual, expected);
         stop_run();
      end
   endtask

   task automatic check_flag(input logic actual, input logic expected, input string what);
      if (actual !== expected)
      begin
         $display("error at %0t ns: %s is %0b, expected %0b", $time, what, actual, expected);
         stop_run();
      end
   endtask

   // 8 cycles of reset, then the idle outputs
   task automatic apply_reset();
      @(negedge clk);
      reset = 1'b1;
      repeat (8) @(negedge clk);
      reset = 1'b0;
      check_flag(busy, 1'b1, "busy_o after reset");
      check_flag(err, 1'b0, "err_o after reset");
      check_flag(data_valid, 1'b0, "data_valid_o after reset");
      check_flag(cs_n, 1'b1, "cs_n_o after reset");
      check_flag(sclk, 1'b0, "sclk_o after reset");
   endtask

   task automatic wait_ready(input string what);
      int cycles;
      cycles = 0;
      while (busy)
      begin
         check_flag(err, 1'b0, {"err_o during ", what});
         if (cycles == TIMEOUT_CYCLES)
         begin
            $display("timeout: busy_o did not fall during %s", what);
            stop_run();
         end
         @(negedge clk);
         cycles++;
      end
   endtask

   // err_o must rise and stick while busy_o stays high
   task automatic wait_error(input string what);
      int cycles;
      cycles = 0;
      while (!err)
      begin
         check_flag(busy, 1'b1, {"busy_o before the error ", what});
         if (cycles == TIMEOUT_CYCLES)
         begin
            $display("timeout: err_o did not rise %s", what);
            stop_run();
         end
         @(negedge clk);
         cycles++;
      end
      repeat (HOLD_CYCLES)
      begin
         @(negedge clk);
         check_flag(busy, 1'b1, {"busy_o held ", what});
         check_flag(err, 1'b1, {"err_o held ", what});
      end
   endtask

   task automatic request_read(input logic [31:0] addr);
      check_flag(busy, 1'b0, "busy_o before a read");
      rd_block = 1'b1;
      block_addr = addr;
      @(negedge clk);
      rd_block = 1'b0;
   endtask

   // pops only on every pop_every-th cycle
   task automatic read_and_check(input logic [31:0] addr, input int pop_every, input string what);
      logic [31:0] expect_state;
      int          base;
      int          popped;
      int          idle;
      int          cycle;
      expect_state = addr ^ PATTERN_SEED;
      base = data_sent;
      popped = 0;
      idle = 0;
      cycle = 0;
      request_read(addr);
      while (popped < `SD_BLOCK_BYTES)
      begin
         @(negedge clk);
         data_pop = 1'b0;
         cycle++;
         idle++;
         check_flag(data_sent - base - popped <= FIFO_DEPTH, 1'b1, {what, " bytes held"});
         check_flag(err, 1'b0, {what, " err_o"});
         if (data_valid && (cycle % pop_every == 0))
         begin
            expect_state = xorshift32(expect_state);
            check_byte(data, expect_state[7:0], {what, " data byte"});
            data_pop = 1'b1;
            popped++;
            idle = 0;
         end
         else if (idle == TIMEOUT_CYCLES)
         begin
            $display("timeout: no data byte arrived for %s", what);
            stop_run();
         end
      end
      @(negedge clk);
      data_pop = 1'b0;
      wait_ready(what);
      check_flag(data_valid, 1'b0, {what, " data_valid_o at the end"});
      check_flag(data_sent - base == `SD_BLOCK_BYTES, 1'b1, {what, " bytes sent by the card"});
   endtask

   task automatic test_init();
      acmd41_busy = 3;
      cmd8_reject = 1'b0;
      apply_reset();
      wait_ready("initialization");
      check_flag(err, 1'b0, "err_o after initialization");
      check_flag(crc_err, 1'b0, "card command crc error");
   endtask

   task automatic test_read_fast();
      read_and_check(32'd5, 1, "block 5");
      check_flag(crc_err, 1'b0, "card command crc error");
   endtask

   task automatic test_back_pressure();
      read_and_check(32'd9, 40, "block 9");
   endtask

   task automatic test_read_error();
      request_read(addr_limit + 32'd7);
      wait_error("after a read above the limit");
      check_flag(data_valid, 1'b0, "data_valid_o after a failed read");
   endtask

   task automatic test_cmd8_reject();
      cmd8_reject = 1'b1;
      apply_reset();
      wait_error("after a rejected cmd8");
   endtask

   initial
   begin
      reset = 1'b1;
      rd_block = 1'b0;
      block_addr = 32'd0;
      data_pop = 1'b0;
      acmd41_busy = 3;
      addr_limit = 32'd100;
      cmd8_reject = 1'b0;
      test_init();
      test_read_fast();
      test_back_pressure();
      test_read_error();
      test_cmd8_reject();
      $display("Simulation PASSED");
      $finish;
   end

endmodule

// ==== dv/sd_card_model.sv ====
`timescale 1ns/1ns
`include "sd_host_macros.svh"

module sd_card_model (
   input  logic        reset,
   input  logic        sclk_i,
   input  logic        mosi_i,
   input  logic        cs_n_i,
   output logic        miso_o,
   input  int          acmd41_busy_i,
   input  logic [31:0] addr_limit_i,
   input  logic        cmd8_reject_i,
   output logic        crc_err_o,
   output int          data_sent_o
);
   import sd_spi_pkg::*;
   import block_pattern_pkg::*;

   byte_t       rsp_q[$];
   bit          is_data_q[$];
   logic [47:0] cmd_sr        = '0;
   byte_t       rx_sr         = 8'hFF;
   byte_t       tx_sr         = 8'hFF;
   logic        miso_q        = 1'b1;
   logic        tx_data       = 1'b0;
   logic        crc_err_q     = 1'b0;
   int          nbits         = 0;
   int          cmd_len       = 0;
   int          acmd41_rounds = 0;
   int          sent_cnt      = 0;

   // bit serial crc7 over the 40 command bits
   function automatic logic [6:0] cmd_crc7(input logic [39:0] bits);
      logic [39:0] d;
      logic [6:0]  crc;
      logic        inv;
      d = bits;
      crc = 7'h00;
      repeat (40)
      begin
         inv = d[39] ^ crc[6];
         crc = {crc[5:0], inv};
         crc[3] = crc[3] ^ inv;
         d = {d[38:0], 1'b0};
      end
      return crc;
   endfunction

   task automatic queue_byte(input byte_t b, input bit is_data);
      rsp_q.push_back(b);
      is_data_q.push_back(is_data);
   endtask

   task automatic answer_cmd();
      logic [39:0] frame;
      logic [31:0] arg;
      logic [31:0] pattern;
      frame = cmd_sr[47:8];
      arg = frame[31:0];
      // one filler byte before r1
      queue_byte(8'hFF, 1'b0);
      if (cmd_sr[7:0] != {cmd_crc7(frame), 1'b1})
      begin
         crc_err_q = 1'b1;
         queue_byte(8'h09, 1'b0);
      end
      else
      begin
         case (frame[37:32])
            6'd0, 6'd55: queue_byte(8'h01, 1'b0);
            6'd8:        queue_byte(cmd8_reject_i ? 8'h05 : 8'h01, 1'b0);
            6'd41:
            begin
               if (acmd41_rounds < acmd41_busy_i)
               begin
                  acmd41_rounds++;
                  queue_byte(8'h01, 1'b0);
               end
               else
               begin
                  queue_byte(8'h00, 1'b0);
               end
            end
            6'd17:
            begin
               if (arg >= addr_limit_i)
               begin
                  // address error
                  queue_byte(8'h40, 1'b0);
               end
               else
               begin
                  queue_byte(8'h00, 1'b0);
                  repeat (3) queue_byte(8'hFF, 1'b0);
                  queue_byte(`SD_START_TOKEN, 1'b0);
                  pattern = arg ^ PATTERN_SEED;
                  repeat (`SD_BLOCK_BYTES)
                  begin
                     pattern = xorshift32(pattern);
                     queue_byte(pattern[7:0], 1'b1);
                  end
                  queue_byte(8'hC3, 1'b0);
                  queue_byte(8'h3C, 1'b0);
               end
            end
            default: queue_byte(8'h05, 1'b0);
         endcase
      end
   endtask

   task automatic take_byte(input byte_t b);
      // a command opens with 01 in the top bits
      if (cmd_len != 0 || b[7:6] == 2'b01)
      begin
         cmd_sr = {cmd_sr[39:0], b};
         cmd_len++;
         if (cmd_len == 6)
         begin
            cmd_len = 0;
            answer_cmd();
         end
      end
   endtask

   always @(posedge sclk_i or negedge sclk_i or posedge reset)
   begin
      if (reset)
      begin
         rsp_q.delete();
         is_data_q.delete();
         nbits = 0;
         cmd_len = 0;
         acmd41_rounds = 0;
         sent_cnt = 0;
         crc_err_q = 1'b0;
         tx_sr = 8'hFF;
         tx_data = 1'b0;
         miso_q = 1'b1;
      end
      else if (sclk_i)
      begin
         rx_sr = {rx_sr[6:0], mosi_i};
         nbits++;
         if (nbits == 8)
         begin
            nbits = 0;
            if (tx_data)
            begin
               sent_cnt++;
            end
            if (!cs_n_i)
            begin
               take_byte(rx_sr);
            end
         end
      end
      else
      begin
         // next byte goes out after the last falling edge
         if (nbits == 0)
         begin
            tx_sr = 8'hFF;
            tx_data = 1'b0;
            if (!cs_n_i && rsp_q.size() > 0)
            begin
               tx_sr = rsp_q.pop_front();
               tx_data = is_data_q.pop_front();
            end
         end
         else
         begin
            tx_sr = {tx_sr[6:0], 1'b1};
         end
         miso_q = tx_sr[7];
      end
   end

   assign miso_o      = cs_n_i ? 1'b1 : miso_q;
   assign crc_err_o   = crc_err_q;
   assign data_sent_o = sent_cnt;

endmodule

// ==== all.f ====
+incdir+verilog
verilog/sd_spi_pkg.sv
verilog/sd_proto_pkg.sv
verilog/spi_byte_if.sv
verilog/sd_link_if.sv
verilog/spi_byte_xfer.sv
verilog/sd_link.sv
verilog/block_fifo.sv
verilog/sd_host_ctrl.sv
verilog/sd_spi_host.sv
dv/tb_sd_spi_host.sv
dv/sd_card_model.sv

// ==== Makefile ====
LOG := sim.log

.PHONY: all build lint clean

all: build
	./obj_dir/sim_tb > $(LOG) 2>&1 || true
	@grep -q "Simulation PASSED" $(LOG) || (tail -n 20 $(LOG); exit 1)
	@tail -n 1 $(LOG)

build:
	verilator --binary --assert -f all.f --top-module tb_sd_spi_host -o sim_tb

lint:
	verilator --lint-only --timing -Wall -f all.f --top-module sd_spi_host

clean:
	rm -rf obj_dir $(LOG)
